//--- common/ifu_defs.svh
`ifndef IFU_DEFS_SVH
`define IFU_DEFS_SVH

// byte address of the first instruction fetch after reset
`define IFU_RESET_PC 32'h0000_0000

// instruction and bus data width
`define IFU_XLEN 32

// wishbone byte address width
`define IFU_ADDR_W 32

`endif

//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

  // major opcodes of the base integer ISA, full 7-bit encodings
  typedef enum logic [6:0] {
    LOAD     = 7'b000_0011,
    MISC_MEM = 7'b000_1111,
    OP_IMM   = 7'b001_0011,
    AUIPC    = 7'b001_0111,
    STORE    = 7'b010_0011,
    OP       = 7'b011_0011,
    LUI      = 7'b011_0111,
    BRANCH   = 7'b110_0011,
    JALR     = 7'b110_0111,
    JAL      = 7'b110_1111,
    SYSTEM   = 7'b111_0011
  } opcode_e;

  // raw 32-bit instruction word
  typedef logic [31:0] inst_t;

  typedef logic [2:0] funct3_t;

  // R-type view of an instruction, the other formats share funct3/rd/opcode
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    funct3_t    funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_fields_t;

endpackage

//--- common/fetch_pkg.sv
`include "ifu_defs.svh"

package fetch_pkg;

  // one word as read from instruction memory
  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] addr;
    logic [`IFU_XLEN-1:0]   data;
  } fetch_word_t;

  // one instruction cut out by the aligner, upper half unused when compressed
  typedef struct packed {
    rv_isa_pkg::inst_t      bits;
    logic [`IFU_ADDR_W-1:0] pc;
    logic                   is_compressed;
  } inst_slot_t;

  typedef struct packed {
    rv_isa_pkg::inst_t inst;
    logic              zc_err;
  } expand_res_t;

  typedef struct packed {
    logic illegal;
  } check_res_t;

  // record handed to the decoder
  typedef struct packed {
    logic [`IFU_ADDR_W-1:0] pc;
    rv_isa_pkg::inst_t      inst;
    logic                   is_compressed;
    logic                   illegal;
  } dec_inst_t;

  typedef enum logic [1:0] {IDLE, BUS, HOLD} fetch_state_e;

endpackage

//--- fetch/wb_fetch.sv
`timescale 1ns/1ns
`include "ifu_defs.svh"

module wb_fetch (
  input  logic                   clk,
  input  logic                   rst_n,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [`IFU_ADDR_W-1:0] wb_adr,
  input  logic [`IFU_XLEN-1:0]   wb_dat_r,
  input  logic                   wb_ack,
  output logic                   word_valid,
  input  logic                   word_ready,
  output fetch_pkg::fetch_word_t word
);

  fetch_pkg::fetch_state_e state;
  fetch_pkg::fetch_state_e state_nxt;
  logic [`IFU_ADDR_W-1:0]  fetch_adr;
  fetch_pkg::fetch_word_t  hold_q;

  // HOLD means the holding register is full, no bus cycle until it drains
  always_comb begin
    state_nxt = state;
    case (state)
      fetch_pkg::IDLE: state_nxt = fetch_pkg::BUS;
      fetch_pkg::BUS: begin
        if (wb_ack) state_nxt = fetch_pkg::HOLD;
      end
      fetch_pkg::HOLD: begin
        if (word_ready) state_nxt = fetch_pkg::BUS;
      end
      default: state_nxt = fetch_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= fetch_pkg::IDLE;
      fetch_adr <= `IFU_RESET_PC;
    end else begin
      state <= state_nxt;
      if (state == fetch_pkg::BUS && wb_ack) fetch_adr <= fetch_adr + `IFU_ADDR_W'(4);
    end
  end

  // word and its address are taken in the ack cycle
  always_ff @(posedge clk) begin
    if (state == fetch_pkg::BUS && wb_ack) begin
      hold_q.data <= wb_dat_r;
      hold_q.addr <= fetch_adr;
    end
  end

  assign wb_cyc     = (state == fetch_pkg::BUS);
  assign wb_stb     = (state == fetch_pkg::BUS);
  assign wb_we      = 1'b0;
  assign wb_adr     = fetch_adr;
  assign word_valid = (state == fetch_pkg::HOLD);
  assign word       = hold_q;

  // classic cycle: request must not move until the slave answers
  property p_req_stable;
    @(posedge clk) disable iff (!rst_n)
      (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr));
  endproperty
  a_req_stable: assert property (p_req_stable);

endmodule

//--- fetch/instr_align.sv
`timescale 1ns/1ns
`include "ifu_defs.svh"

module instr_align (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   word_valid,
  output logic                   word_ready,
  input  fetch_pkg::fetch_word_t word,
  output logic                   slot_valid,
  input  logic                   slot_ready,
  output fetch_pkg::inst_slot_t  slot
);

  // the current word stays in the fetch holding register until consumed,
  // only the upper leftover halfword is kept here
  logic [15:0]            lo_hw;
  logic                   lo_valid;
  logic [`IFU_ADDR_W-1:0] lo_pc;
  logic                   lo_is_rvc;
  logic                   word_lo_rvc;
  logic                   slot_fire;
  logic                   word_fire;

  assign lo_is_rvc   = (lo_hw[1:0] != 2'b11);
  assign word_lo_rvc = (word.data[1:0] != 2'b11);
  assign slot_fire   = slot_valid && slot_ready;
  assign word_fire   = word_valid && word_ready;

  always_comb begin
    slot_valid         = word_valid;
    word_ready         = slot_ready;
    slot.bits          = word.data;
    slot.pc            = word.addr;
    slot.is_compressed = word_lo_rvc;
    if (lo_valid && lo_is_rvc) begin
      // leftover is a whole compressed instruction, word untouched
      slot_valid         = 1'b1;
      word_ready         = 1'b0;
      slot.bits          = {16'h0000, lo_hw};
      slot.pc            = lo_pc;
      slot.is_compressed = 1'b1;
    end else if (lo_valid) begin
      // 32-bit instruction crossing the word boundary
      slot.bits          = {word.data[15:0], lo_hw};
      slot.pc            = lo_pc;
      slot.is_compressed = 1'b0;
    end
  end

  // a consumed word leaves its upper half behind unless a 32-bit
  // instruction starting at the word base used all of it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lo_valid <= 1'b0;
    end else if (slot_fire) begin
      lo_valid <= word_fire ? (lo_valid || word_lo_rvc) : 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (word_fire) begin
      lo_hw <= word.data[31:16];
      lo_pc <= word.addr + `IFU_ADDR_W'(2);
    end
  end

  property p_pc_aligned;
    @(posedge clk) disable iff (!rst_n)
      slot_valid |-> (slot.pc[0] == 1'b0);
  endproperty
  a_pc_aligned: assert property (p_pc_aligned);

endmodule

//--- verilog/rvc_expand.sv
`timescale 1ns/1ns

module rvc_expand (
  input  fetch_pkg::inst_slot_t  slot,
  output fetch_pkg::expand_res_t res
);

  logic [15:0]       c;
  rv_isa_pkg::inst_t inst;
  logic              zc_err;

  assign c = slot.bits[15:0];

  always_comb begin
    inst   = slot.bits;
    zc_err = 1'b0;
    if (slot.is_compressed) begin
      case (c[1:0])
        // quadrant 0
        2'b00: begin
          case (c[15:13])
            3'b000: begin
              // c.addi4spn, zero immediate is reserved
              inst = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'h02, 3'b000,
                      2'b01, c[4:2], rv_isa_pkg::OP_IMM};
              if (c[12:5] == 8'b0) zc_err = 1'b1;
            end
            3'b010: begin
              inst = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                      2'b01, c[4:2], rv_isa_pkg::LOAD};
            end
            3'b100: begin
              // zcb loads and stores
              case (c[12:10])
                3'b000: inst = {10'b0, c[5], c[6], 2'b01, c[9:7], 3'b100, 2'b01, c[4:2],
                                rv_isa_pkg::LOAD};
                3'b001: inst = {10'b0, c[5], 1'b0, 2'b01, c[9:7], c[6] ? 3'b001 : 3'b101,
                                2'b01, c[4:2], rv_isa_pkg::LOAD};
                3'b010: inst = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b000, 3'b0, c[5], c[6],
                                rv_isa_pkg::STORE};
                3'b011: begin
                  inst = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b001, 3'b0, c[5], 1'b0,
                          rv_isa_pkg::STORE};
                  if (c[6]) zc_err = 1'b1;
                end
                default: zc_err = 1'b1;
              endcase
            end
            3'b110: begin
              inst = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010,
                      c[11:10], c[6], 2'b00, rv_isa_pkg::STORE};
            end
            // odd rows are reserved
            default: zc_err = 1'b1;
          endcase
        end
        // quadrant 1, register checks left to the decoder
        2'b01: begin
          case (c[15:13])
            3'b000: inst = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b0, c[11:7],
                            rv_isa_pkg::OP_IMM};
            // c.jal links x1, c.j links x0
            3'b001, 3'b101: inst = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                    {9{c[12]}}, 4'b0, ~c[15], rv_isa_pkg::JAL};
            3'b010: inst = {{6{c[12]}}, c[12], c[6:2], 5'b0, 3'b0, c[11:7],
                            rv_isa_pkg::OP_IMM};
            3'b011: begin
              inst = {{15{c[12]}}, c[6:2], c[11:7], rv_isa_pkg::LUI};
              // rd x2 turns c.lui into c.addi16sp
              if (c[11:7] == 5'h02) begin
                inst = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0, 5'h02, 3'b000, 5'h02,
                        rv_isa_pkg::OP_IMM};
              end
              if ({c[12], c[6:2]} == 6'b0) zc_err = 1'b1;
            end
            3'b100: begin
              case (c[11:10])
                2'b00, 2'b01: begin
                  // srli or srai, shamt[5] set is reserved on rv32
                  inst = {1'b0, c[10], 5'b0, c[6:2], 2'b01, c[9:7], 3'b101, 2'b01, c[9:7],
                          rv_isa_pkg::OP_IMM};
                  if (c[12]) zc_err = 1'b1;
                end
                2'b10: inst = {{6{c[12]}}, c[12], c[6:2], 2'b01, c[9:7], 3'b111, 2'b01,
                               c[9:7], rv_isa_pkg::OP_IMM};
                default: begin
                  case ({c[12], c[6:5]})
                    3'b000: inst = {7'b010_0000, 2'b01, c[4:2], 2'b01, c[9:7], 3'b000,
                                    2'b01, c[9:7], rv_isa_pkg::OP};
                    3'b001: inst = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b100, 2'b01,
                                    c[9:7], rv_isa_pkg::OP};
                    3'b010: inst = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b110, 2'b01,
                                    c[9:7], rv_isa_pkg::OP};
                    3'b011: inst = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b111, 2'b01,
                                    c[9:7], rv_isa_pkg::OP};
                    // c.mul
                    3'b110: inst = {7'b1, 2'b01, c[4:2], 2'b01, c[9:7], 3'b000, 2'b01,
                                    c[9:7], rv_isa_pkg::OP};
                    3'b111: begin
                      // zext.b and not, the zbb forms are not supported
                      case (c[4:2])
                        3'b000: inst = {12'h0ff, 2'b01, c[9:7], 3'b111, 2'b01, c[9:7],
                                        rv_isa_pkg::OP_IMM};
                        3'b101: inst = {12'hfff, 2'b01, c[9:7], 3'b100, 2'b01, c[9:7],
                                        rv_isa_pkg::OP_IMM};
                        default: zc_err = 1'b1;
                      endcase
                    end
                    default: zc_err = 1'b1;
                  endcase
                end
              endcase
            end
            // beqz and bnez, funct3 bit 0 comes from c[13]
            default: inst = {{4{c[12]}}, c[6:5], c[2], 5'b0, 2'b01, c[9:7], 2'b00, c[13],
                             c[11:10], c[4:3], c[12], rv_isa_pkg::BRANCH};
          endcase
        end
        // quadrant 2
        default: begin
          case (c[15:13])
            3'b000: begin
              inst = {7'b0, c[6:2], c[11:7], 3'b001, c[11:7], rv_isa_pkg::OP_IMM};
              if (c[12]) zc_err = 1'b1;
            end
            3'b010: begin
              inst = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'h02, 3'b010, c[11:7],
                      rv_isa_pkg::LOAD};
              if (c[11:7] == 5'b0) zc_err = 1'b1;
            end
            3'b100: begin
              if (c[6:2] != 5'b0) begin
                // mv when c[12] is clear, otherwise add
                inst = {7'b0, c[6:2], c[12] ? c[11:7] : 5'b0, 3'b0, c[11:7], rv_isa_pkg::OP};
              end else if (!c[12]) begin
                inst = {12'b0, c[11:7], 3'b0, 5'b0, rv_isa_pkg::JALR};
                if (c[11:7] == 5'b0) zc_err = 1'b1;
              end else if (c[11:7] == 5'b0) begin
                inst = {12'h001, 5'b0, 3'b0, 5'b0, rv_isa_pkg::SYSTEM};
              end else begin
                inst = {12'b0, c[11:7], 3'b000, 5'b00001, rv_isa_pkg::JALR};
              end
            end
            3'b110: begin
              inst = {4'b0, c[8:7], c[12], c[6:2], 5'h02, 3'b010, c[11:9], 2'b00,
                      rv_isa_pkg::STORE};
            end
            default: zc_err = 1'b1;
          endcase
        end
      endcase
    end
  end

  assign res.inst   = inst;
  assign res.zc_err = zc_err;

endmodule

//--- verilog/base_check.sv
`timescale 1ns/1ns

module base_check (
  input  fetch_pkg::inst_slot_t slot,
  output fetch_pkg::check_res_t res
);

  rv_isa_pkg::inst_fields_t f;
  logic                     illegal;

  assign f = slot.bits;

  always_comb begin
    case (f.opcode)
      rv_isa_pkg::LOAD:   illegal = (f.funct3 == 3'd3) || (f.funct3 >= 3'd6);
      rv_isa_pkg::STORE:  illegal = (f.funct3 > 3'd2);
      rv_isa_pkg::BRANCH: illegal = (f.funct3 == 3'd2) || (f.funct3 == 3'd3);
      rv_isa_pkg::JALR:   illegal = (f.funct3 != 3'd0);
      // funct3 of these is decoded further down the pipe
      rv_isa_pkg::MISC_MEM,
      rv_isa_pkg::OP_IMM,
      rv_isa_pkg::AUIPC,
      rv_isa_pkg::OP,
      rv_isa_pkg::LUI,
      rv_isa_pkg::JAL,
      rv_isa_pkg::SYSTEM: illegal = 1'b0;
      default:            illegal = 1'b1;
    endcase
  end

  assign res.illegal = illegal;

endmodule

//--- verilog/instr_merge.sv
`timescale 1ns/1ns

module instr_merge (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   slot_valid,
  output logic                   slot_ready,
  input  fetch_pkg::inst_slot_t  slot,
  input  fetch_pkg::expand_res_t exp_res,
  input  fetch_pkg::check_res_t  chk_res,
  output logic                   out_valid,
  input  logic                   out_ready,
  output fetch_pkg::dec_inst_t   out_inst
);

  fetch_pkg::dec_inst_t rec;

  always_comb begin
    rec.pc            = slot.pc;
    rec.is_compressed = slot.is_compressed;
    rec.inst          = slot.is_compressed ? exp_res.inst : slot.bits;
    rec.illegal       = slot.is_compressed ? exp_res.zc_err : chk_res.illegal;
  end

  // single slice, refills in the cycle it drains
  assign slot_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) out_valid <= 1'b0;
    else if (slot_ready) out_valid <= slot_valid;
  end

  always_ff @(posedge clk) begin
    if (slot_valid && slot_ready) out_inst <= rec;
  end

  property p_out_hold;
    @(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_inst));
  endproperty
  a_out_hold: assert property (p_out_hold);

endmodule

//--- verilog/ifu_top.sv
`timescale 1ns/1ns
`include "ifu_defs.svh"

module ifu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [`IFU_ADDR_W-1:0] wb_adr,
  input  logic [`IFU_XLEN-1:0]   wb_dat_r,
  input  logic                   wb_ack,
  output logic                   out_valid,
  input  logic                   out_ready,
  output fetch_pkg::dec_inst_t   out_inst
);

  logic                   word_valid;
  logic                   word_ready;
  fetch_pkg::fetch_word_t word;
  logic                   slot_valid;
  logic                   slot_ready;
  fetch_pkg::inst_slot_t  slot;
  fetch_pkg::expand_res_t exp_res;
  fetch_pkg::check_res_t  chk_res;

  wb_fetch u_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .word_valid(word_valid),
    .word_ready(word_ready),
    .word      (word)
  );

  instr_align u_align (
    .clk       (clk),
    .rst_n     (rst_n),
    .word_valid(word_valid),
    .word_ready(word_ready),
    .word      (word),
    .slot_valid(slot_valid),
    .slot_ready(slot_ready),
    .slot      (slot)
  );

  // expander and checker both look at every slot, merge picks one
  rvc_expand u_expand (
    .slot(slot),
    .res (exp_res)
  );

  base_check u_check (
    .slot(slot),
    .res (chk_res)
  );

  instr_merge u_merge (
    .clk       (clk),
    .rst_n     (rst_n),
    .slot_valid(slot_valid),
    .slot_ready(slot_ready),
    .slot      (slot),
    .exp_res   (exp_res),
    .chk_res   (chk_res),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_inst  (out_inst)
  );

endmodule

//--- sim/tb_wb_mem.sv
`timescale 1ns/1ns
`include "ifu_defs.svh"

module tb_wb_mem #(
  parameter int DEPTH = 256
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  logic [`IFU_ADDR_W-1:0] adr,
  output logic [`IFU_XLEN-1:0]   dat_r,
  output logic                   ack
);

  localparam int IW = $clog2(DEPTH);

  logic [`IFU_XLEN-1:0] mem [0:DEPTH-1];
  integer               seed;
  int                   wait_cnt;

  // background pattern from the full word index, program is written over it
  initial begin
    seed     = 42;
    ack      = 1'b0;
    dat_r    = '0;
    wait_cnt = 0;
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 32'(i) * 32'h9e37_79b9;
    end
  end

  // outputs move on the falling edge, 0 to 3 wait states per read
  always @(negedge clk) begin
    if (!rst_n) begin
      ack      <= 1'b0;
      wait_cnt <= 0;
    end else if (ack) begin
      ack <= 1'b0;
    end else if (cyc && stb && !we) begin
      if (wait_cnt == 0) begin
        ack      <= 1'b1;
        dat_r    <= mem[adr[IW+1:2]];
        wait_cnt <= $unsigned($random(seed)) % 4;
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

//--- sim/tb_ifu.sv
`timescale 1ns/1ns
`include "ifu_defs.svh"

module tb_ifu;

  typedef struct packed {
    logic [31:0]       enc;
    logic [2:0]        len;
    rv_isa_pkg::inst_t exp_inst;
    logic              exp_ill;
  } entry_t;

  localparam int RESET_CYCLES = 16;

  logic                   clk;
  logic                   rst_n;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [`IFU_ADDR_W-1:0] wb_adr;
  logic [`IFU_XLEN-1:0]   wb_dat_r;
  logic                   wb_ack;
  logic                   out_valid;
  logic                   out_ready;
  fetch_pkg::dec_inst_t   out_inst;
  fetch_pkg::dec_inst_t   held;

  entry_t                 vectors[$];
  logic [`IFU_ADDR_W-1:0] exp_pc[$];
  integer                 seed;
  int                     errors;
  int                     idx;
  int                     cycles;
  int                     limit;
  logic                   hold_pending;
  logic                   finished;
  logic                   timed_out;

  ifu_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_inst (out_inst)
  );

  tb_wb_mem u_mem (
    .clk  (clk),
    .rst_n(rst_n),
    .cyc  (wb_cyc),
    .stb  (wb_stb),
    .we   (wb_we),
    .adr  (wb_adr),
    .dat_r(wb_dat_r),
    .ack  (wb_ack)
  );

  always #10 clk = ~clk;

  task automatic check_inst(input string name, input rv_isa_pkg::inst_t got,
                            input rv_isa_pkg::inst_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_pc(input string name, input logic [`IFU_ADDR_W-1:0] got,
                          input logic [`IFU_ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic add_vec(input logic [31:0] enc, input logic [2:0] len,
                         input rv_isa_pkg::inst_t exp, input logic ill);
    entry_t e;
    e.enc      = enc;
    e.len      = len;
    e.exp_inst = exp;
    e.exp_ill  = ill;
    vectors.push_back(e);
  endtask

  // quadrant 0, 1 and 2 forms use x8 to x15 for the compact registers
  task automatic build_vectors();
    add_vec(32'h0040, 2, 32'h0041_0413, 0);  // addi4spn x8, 4
    add_vec(32'h0031_00b3, 4, 32'h0031_00b3, 0);  // add crossing a word boundary
    add_vec(32'h4044, 2, 32'h0044_2483, 0);  // lw
    add_vec(32'hc044, 2, 32'h0094_2223, 0);  // sw
    add_vec(32'h147d, 2, 32'hfff4_0413, 0);  // addi -1
    add_vec(32'h2021, 2, 32'h0080_00ef, 0);  // jal +8
    add_vec(32'h4515, 2, 32'h0050_0513, 0);  // li
    add_vec(32'h0083_2283, 4, 32'h0083_2283, 0);
    add_vec(32'h6585, 2, 32'h0000_15b7, 0);  // lui
    add_vec(32'h6141, 2, 32'h0101_0113, 0);  // addi16sp
    add_vec(32'h8005, 2, 32'h0014_5413, 0);  // srli
    add_vec(32'h8489, 2, 32'h4024_d493, 0);  // srai
    add_vec(32'h997d, 2, 32'hfff5_7513, 0);  // andi
    add_vec(32'h1234_52b7, 4, 32'h1234_52b7, 0);
    add_vec(32'h8c05, 2, 32'h4094_0433, 0);  // sub
    add_vec(32'h8c25, 2, 32'h0094_4433, 0);  // xor
    add_vec(32'h8c45, 2, 32'h0094_6433, 0);  // or
    add_vec(32'h8c65, 2, 32'h0094_7433, 0);  // and
    add_vec(32'hc011, 2, 32'h0004_0263, 0);  // beqz
    add_vec(32'he011, 2, 32'h0004_1263, 0);  // bnez
    add_vec(32'h040e, 2, 32'h0034_1413, 0);  // slli
    add_vec(32'h0000_005b, 4, 32'h0000_005b, 1);  // unknown opcode
    add_vec(32'h4492, 2, 32'h0041_2483, 0);  // lwsp
    add_vec(32'h852e, 2, 32'h00b0_0533, 0);  // mv
    add_vec(32'h8082, 2, 32'h0000_8067, 0);  // jr
    add_vec(32'h952e, 2, 32'h00b5_0533, 0);  // add
    add_vec(32'h9282, 2, 32'h0002_80e7, 0);  // jalr
    add_vec(32'h9002, 2, 32'h0010_0073, 0);  // ebreak
    add_vec(32'hc226, 2, 32'h0091_2223, 0);  // swsp
    add_vec(32'h0003_3283, 4, 32'h0003_3283, 1);  // load funct3 3
    add_vec(32'h8044, 2, 32'h0014_4483, 0);  // zcb lbu
    add_vec(32'h8424, 2, 32'h0024_5483, 0);  // zcb lhu
    add_vec(32'h8464, 2, 32'h0024_1483, 0);  // zcb lh
    add_vec(32'h8844, 2, 32'h0094_00a3, 0);  // zcb sb
    add_vec(32'h8c24, 2, 32'h0094_1123, 0);  // zcb sh
    add_vec(32'h9c61, 2, 32'h0ff4_7413, 0);  // zext.b
    add_vec(32'h9c75, 2, 32'hfff4_4413, 0);  // not
    add_vec(32'h9c45, 2, 32'h0294_0433, 0);  // mul
    add_vec(32'h0053_3023, 4, 32'h0053_3023, 1);  // store funct3 3
    add_vec(32'h0004, 2, 32'h0000_0000, 1);  // addi4spn zero imm
    add_vec(32'h4012, 2, 32'h0000_0000, 1);  // lwsp x0
    add_vec(32'h8c64, 2, 32'h0000_0000, 1);  // c.sh with bit 6
    add_vec(32'h2000, 2, 32'h0000_0000, 1);  // c0 odd row
    add_vec(32'h0000_2063, 4, 32'h0000_2063, 1);  // branch funct3 2
    add_vec(32'h0000_1067, 4, 32'h0000_1067, 1);  // jalr funct3 1
    add_vec(32'h0020_8463, 4, 32'h0020_8463, 0);
  endtask

  // pack encodings as halfwords with the low half first and note each PC
  task automatic load_memory();
    logic [15:0]            halves[$];
    logic [`IFU_ADDR_W-1:0] pc;
    pc = `IFU_RESET_PC;
    foreach (vectors[i]) begin
      exp_pc.push_back(pc);
      halves.push_back(vectors[i].enc[15:0]);
      if (vectors[i].len == 3'd4) halves.push_back(vectors[i].enc[31:16]);
      pc = pc + `IFU_ADDR_W'(vectors[i].len);
    end
    if (halves.size() % 2 != 0) halves.push_back(16'h0001);
    for (int w = 0; w < halves.size() / 2; w++) begin
      u_mem.mem[w] = {halves[2*w+1], halves[2*w]};
    end
  endtask

  task automatic check_entry(input int i);
    entry_t e;
    e = vectors[i];
    check_pc("out_inst.pc", out_inst.pc, exp_pc[i]);
    check_flag("out_inst.is_compressed", out_inst.is_compressed, e.len == 3'd2);
    check_flag("out_inst.illegal", out_inst.illegal, e.exp_ill);
    // reserved compressed encodings have no defined expansion
    if (!(e.len == 3'd2 && e.exp_ill)) check_inst("out_inst.inst", out_inst.inst, e.exp_inst);
  endtask

  // valid and ready seen here hold until the next rising edge
  always @(negedge clk) begin
    out_ready = ($unsigned($random(seed)) % 3) != 0;
    if (rst_n && !finished) begin
      // cyc follows stb in classic single reads and we stays low
      check_flag("wb_cyc", wb_cyc, wb_stb);
      check_flag("wb_we", wb_we, 1'b0);
      if (hold_pending) begin
        check_flag("out_valid", out_valid, 1'b1);
        check_pc("out_inst.pc", out_inst.pc, held.pc);
        check_inst("out_inst.inst", out_inst.inst, held.inst);
        check_flag("out_inst.is_compressed", out_inst.is_compressed, held.is_compressed);
        check_flag("out_inst.illegal", out_inst.illegal, held.illegal);
      end
      hold_pending = 1'b0;
      if (out_valid && out_ready) begin
        check_entry(idx);
        idx++;
        if (idx == vectors.size()) finished = 1'b1;
      end else if (out_valid) begin
        hold_pending = 1'b1;
        held         = out_inst;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && !finished && !timed_out) begin
      cycles++;
      if (cycles >= limit) begin
        $display("timeout after %0d cycles, %0d of %0d instructions seen",
                 cycles, idx, vectors.size());
        timed_out = 1'b1;
      end
    end
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    out_ready    = 1'b0;
    seed         = 42;
    errors       = 0;
    idx          = 0;
    cycles       = 0;
    hold_pending = 1'b0;
    finished     = 1'b0;
    timed_out    = 1'b0;
    build_vectors();
    limit = 40 * vectors.size() + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    load_memory();
    @(negedge clk);
    rst_n = 1'b1;
    wait (finished || timed_out);
    @(negedge clk);
    $display("%0d errors, %0d of %0d instructions checked", errors, idx, vectors.size());
    if (errors == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+common
common/rv_isa_pkg.sv
common/fetch_pkg.sv
fetch/wb_fetch.sv
fetch/instr_align.sv
verilog/rvc_expand.sv
verilog/base_check.sv
verilog/instr_merge.sv
verilog/ifu_top.sv
sim/tb_wb_mem.sv
sim/tb_ifu.sv

//--- run.sh
#!/bin/bash
# build and run the instruction fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ifu -f files.f \
  && ./obj_dir/Vtb_ifu > sim.log 2>&1
[ -f sim.log ] || exit 1
cat sim.log
grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0
